// ==== Bender.yml ====
package:
  name: mac_engine

sources:
  - design/mac_pkg.sv
  - design/mac_ctrl.sv
  - design/pp_gen.sv
  - design/csa_tree.sv
  - design/accum_adder.sv
  - design/mac_top.sv
  - target: test
    files:
      - test/mac_tb.sv

// ==== design/accum_adder.sv ====
// carry-propagate adder, accumulator register, feedback masking, tree check

`timescale 1ns/10ps

module accum_adder import mac_pkg::*;
(
	input logic clk,
	input logic rst,
	input stage_t stage,
	input acc_t sum,
	input acc_t carry,
	input pp_rows_t rows,
	output acc_t fb_row,
	output acc_t result
);

	acc_t acc;
	acc_t total;

	// sum of the partial-product rows, wraps at ACC_W
	function automatic acc_t row_total(input pp_rows_t r);
		acc_t t;
		t = '0;
		for (int i = 0; i < PP_ROWS; i++)
			t = t + r[i];
		return t;
	endfunction

	// ----------------------------------------
	// feedback and final add
	// ----------------------------------------

	// first sample of a burst starts from zero
	assign fb_row = stage.first ? '0 : acc;

	// resolve the redundant pair, modulo 2^ACC_W
	assign total = sum + carry;

	always_ff @(posedge clk)
	begin
		if (rst)
			acc <= '0;
		else if (stage.valid)
			acc <= total;
	end

	assign result = acc;

	// tree output must match the plain sum of its inputs
	assert property (@(posedge clk) disable iff (rst)
		stage.valid |-> (total == acc_t'(fb_row + row_total(rows))));

endmodule

// ==== design/csa_tree.sv ====
// generic Wallace-tree compressor built from 3:2 carry-save layers

`timescale 1ns/10ps

module csa_tree import mac_pkg::*;
#(
	parameter int NUM_ROWS = TREE_ROWS,
	parameter int ROW_W = ACC_W
)
(
	input logic [NUM_ROWS-1:0][ROW_W-1:0] rows_in,
	output logic [ROW_W-1:0] sum,
	output logic [ROW_W-1:0] carry
);

	// ----------------------------------------
	// layer sizing at elaboration
	// ----------------------------------------

	// rows left after one 3:2 layer
	function automatic int rows_after(input int n);
		return (n / 3) * 2 + (n % 3);
	endfunction

	// rows entering layer l
	function automatic int rows_at(input int n, input int l);
		int r;
		r = n;
		for (int i = 0; i < l; i++)
			r = rows_after(r);
		return r;
	endfunction

	// layers needed to get down to two rows
	function automatic int layer_count(input int n);
		int r;
		int c;
		r = n;
		c = 0;
		while (r > 2)
		begin
			r = rows_after(r);
			c++;
		end
		return c;
	endfunction

	localparam int NLAYERS = layer_count(NUM_ROWS);

	// layer 0 is the input, layer NLAYERS holds the final pair
	logic [ROW_W-1:0] lyr [NLAYERS+1][NUM_ROWS];

	for (genvar r = 0; r < NUM_ROWS; r++)
	begin : g_in
		assign lyr[0][r] = rows_in[r];
	end

	// ----------------------------------------
	// carry-save layers
	// ----------------------------------------

	for (genvar l = 0; l < NLAYERS; l++)
	begin : g_layer
		localparam int N_IN = rows_at(NUM_ROWS, l);
		localparam int GRP = N_IN / 3;
		localparam int REM = N_IN % 3;
		localparam int N_OUT = GRP * 2 + REM;

		// each group of three becomes a sum row and a shifted carry row
		for (genvar g = 0; g < GRP; g++)
		begin : g_csa
			logic [ROW_W-1:0] x, y, z;
			assign x = lyr[l][3*g];
			assign y = lyr[l][3*g+1];
			assign z = lyr[l][3*g+2];
			assign lyr[l+1][2*g] = x ^ y ^ z;
			// majority moves up one bit, top carry drops out
			assign lyr[l+1][2*g+1] = ((x & y) | (y & z) | (z & x)) << 1;
		end

		// one or two leftovers go straight down
		for (genvar r = 0; r < REM; r++)
		begin : g_pass
			assign lyr[l+1][2*GRP+r] = lyr[l][3*GRP+r];
		end

		// unused slots of this layer
		for (genvar r = N_OUT; r < NUM_ROWS; r++)
		begin : g_unused
			assign lyr[l+1][r] = '0;
		end
	end

	// ----------------------------------------
	// final pair
	// ----------------------------------------

	if (NUM_ROWS == 1)
	begin : g_single
		// lone row is already the sum
		assign sum = lyr[0][0];
		assign carry = '0;
	end
	else
	begin : g_pair
		// two inputs skip the layers entirely
		assign sum = lyr[NLAYERS][0];
		assign carry = lyr[NLAYERS][1];
	end

endmodule

// ==== design/mac_ctrl.sv ====
// burst control FSM, stage-1 flag register, sample counter and output strobe

`timescale 1ns/10ps

module mac_ctrl import mac_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic in_last,
	output stage_t stage,
	output logic out_valid,
	output cnt_t count
);

	ctrl_state_t state;
	cnt_t cnt_q;
	cnt_t cnt_next;

	// ----------------------------------------
	// burst state
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= ST_IDLE;
		else if (in_valid)
			// a last sample closes the burst and anything else keeps it open
			state <= in_last ? ST_IDLE : ST_BURST;
	end

	// ----------------------------------------
	// stage 1 flags loaded at E0
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		if (rst)
			stage <= '0;
		else
		begin
			stage.valid <= in_valid;
			// idle means no burst open so this sample starts one
			stage.first <= in_valid && (state == ST_IDLE);
			stage.last <= in_valid && in_last;
		end
	end

	// ----------------------------------------
	// sample count and output strobe at E1
	// ----------------------------------------

	// restart at one for a new burst
	assign cnt_next = stage.first ? cnt_t'(1) : cnt_q + cnt_t'(1);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cnt_q <= '0;
			count <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			if (stage.valid)
				cnt_q <= cnt_next;
			// same edge the accumulator takes the final sum
			out_valid <= stage.valid && stage.last;
			if (stage.valid && stage.last)
				count <= cnt_next;
		end
	end

	// last flag only rides on a real sample
	assert property (@(posedge clk) disable iff (rst) in_last |-> in_valid);

endmodule

// ==== design/mac_pkg.sv ====
// widths, row counts, vector typedefs, control state enum and stage-1 struct

package mac_pkg;

	// ----------------------------------------
	// sizes
	// ----------------------------------------

	// unsigned sample width
	localparam int OP_W = 8;
	// accumulator and tree row width
	localparam int ACC_W = 24;
	// sample counter, wraps at 256
	localparam int CNT_W = 8;
	// one row per multiplier bit
	localparam int PP_ROWS = OP_W;
	// partial products plus the accumulator feedback row
	localparam int TREE_ROWS = PP_ROWS + 1;

	// ----------------------------------------
	// vector types
	// ----------------------------------------

	typedef logic [OP_W-1:0] op_t;
	typedef logic [ACC_W-1:0] acc_t;
	typedef logic [CNT_W-1:0] cnt_t;

	// row i = a & b[i], shifted left by i
	typedef acc_t [PP_ROWS-1:0] pp_rows_t;

	// sample held in stage 1
	typedef struct packed {
		logic valid;
		logic first;
		logic last;
	} stage_t;

	// burst tracking
	typedef enum logic {
		ST_IDLE,
		ST_BURST
	} ctrl_state_t;

endpackage

// ==== design/mac_top.sv ====
// top level of the multiply-accumulate engine, control plus datapath

`timescale 1ns/10ps

module mac_top import mac_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic in_last,
	input op_t a,
	input op_t b,
	output logic out_valid,
	output acc_t result,
	output cnt_t count
);

	stage_t stage;
	pp_rows_t rows;
	acc_t fb_row;
	acc_t sum;
	acc_t carry;

	// feedback row sits at index 0 of the tree input
	logic [TREE_ROWS-1:0][ACC_W-1:0] tree_in;

	assign tree_in = {rows, fb_row};

	// ----------------------------------------
	// control
	// ----------------------------------------

	mac_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_last(in_last),
		.stage(stage),
		.out_valid(out_valid),
		.count(count)
	);

	// ----------------------------------------
	// datapath
	// ----------------------------------------

	pp_gen u_pp (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.a(a),
		.b(b),
		.rows(rows)
	);

	csa_tree #(.NUM_ROWS(TREE_ROWS), .ROW_W(ACC_W)) u_tree (
		.rows_in(tree_in),
		.sum(sum),
		.carry(carry)
	);

	accum_adder u_acc (
		.clk(clk),
		.rst(rst),
		.stage(stage),
		.sum(sum),
		.carry(carry),
		.rows(rows),
		.fb_row(fb_row),
		.result(result)
	);

endmodule

// ==== design/pp_gen.sv ====
// operand register stage and generation of the shifted partial-product rows

`timescale 1ns/10ps

module pp_gen import mac_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input op_t a,
	input op_t b,
	output pp_rows_t rows
);

	// held operands for stage 1
	op_t a_q;
	op_t b_q;

	// ----------------------------------------
	// operand registers, E0
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			a_q <= '0;
			b_q <= '0;
		end
		else if (in_valid)
		begin
			a_q <= a;
			b_q <= b;
		end
		// otherwise hold the last pair
	end

	// ----------------------------------------
	// partial products
	// ----------------------------------------

	// multiplicand zero-extended to tree width
	acc_t a_ext;

	assign a_ext = acc_t'(a_q);

	// one row per multiplier bit, at its own weight
	always_comb
	begin
		for (int i = 0; i < PP_ROWS; i++)
		begin
			if (b_q[i])
				rows[i] = a_ext << i;
			else
				rows[i] = '0;
		end
	end

endmodule

// ==== tb.f ====
design/mac_pkg.sv
design/mac_ctrl.sv
design/pp_gen.sv
design/csa_tree.sv
design/accum_adder.sv
design/mac_top.sv
test/mac_tb.sv

// ==== test/mac_tb.sv ====
// mac_top testbench with clock, reset, reference model, directed tests and watchdog

`timescale 1ns/10ps

module mac_tb import mac_pkg::*;
();

	localparam int CLK_NS = 4;
	localparam int B2B_BURSTS = 12;
	localparam int GAP_BURSTS = 5;
	localparam int WRAP_LEN = 300;
	// worst case per test for reset, corners, back-to-back, gapped, wrap and drain
	localparam int TEST_CYCLES = 3 + 16 + B2B_BURSTS * 20 + 3
		+ GAP_BURSTS * (20 * 4 + 3) + 3 + WRAP_LEN + 3 + 4;
	localparam int WATCHDOG_CYCLES = TEST_CYCLES + 100;

	logic clk = 1'b0;
	logic rst;
	logic in_valid;
	logic in_last;
	op_t a;
	op_t b;
	logic out_valid;
	acc_t result;
	cnt_t count;

	integer seed = 63;
	int ncyc = 0;
	int value_errs = 0;
	int proto_errs = 0;

	// reference model of the open burst
	acc_t model_acc = '0;
	int burst_len = 0;

	// expected strobes in order of arrival
	int due_q[$];
	acc_t res_q[$];
	cnt_t exp_cnt_q[$];

	mac_top UUT (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_last(in_last),
		.a(a),
		.b(b),
		.out_valid(out_valid),
		.result(result),
		.count(count)
	);

	always #(CLK_NS / 2) clk = ~clk;

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------

	function automatic op_t rand_op();
		return op_t'($random(seed));
	endfunction

	// one accepted sample with the model updated alongside
	task automatic send_sample(input op_t sa, input op_t sb, input logic last);
		@(posedge clk);
		in_valid <= 1'b1;
		in_last <= last;
		a <= sa;
		b <= sb;
		model_acc = model_acc + acc_t'(sa) * acc_t'(sb);
		burst_len++;
		if (last)
		begin
			// strobe due at the negedge after E1
			due_q.push_back(ncyc + 3);
			res_q.push_back(model_acc);
			exp_cnt_q.push_back(cnt_t'(burst_len % 256));
			model_acc = '0;
			burst_len = 0;
		end
	endtask

	// idle cycles with scrambled operands that the DUT must ignore
	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			in_valid <= 1'b0;
			in_last <= 1'b0;
			a <= rand_op();
			b <= rand_op();
		end
	endtask

	// ----------------------------------------
	// output monitor
	// ----------------------------------------

	always @(negedge clk)
	begin
		ncyc++;
		if (due_q.size() > 0 && due_q[0] == ncyc)
		begin
			assert (out_valid === 1'b1)
			else
			begin
				$display("out_valid missing at cycle %0d", ncyc);
				proto_errs++;
			end
			if (out_valid === 1'b1)
			begin
				assert (result === res_q[0])
				else
				begin
					$display("mismatch result: expected %h, got %h", res_q[0], result);
					value_errs++;
				end
				assert (count === exp_cnt_q[0])
				else
				begin
					$display("mismatch count: expected %h, got %h", exp_cnt_q[0], count);
					value_errs++;
				end
			end
			void'(due_q.pop_front());
			void'(res_q.pop_front());
			void'(exp_cnt_q.pop_front());
		end
		else
		begin
			// covers reset, idle time and double-wide strobes
			assert (out_valid === 1'b0)
			else
			begin
				$display("unexpected out_valid at cycle %0d", ncyc);
				proto_errs++;
			end
		end
	end

	// ----------------------------------------
	// directed tests
	// ----------------------------------------

	task automatic check_reset;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (result === '0)
		else
		begin
			$display("mismatch result: expected %h, got %h", acc_t'(0), result);
			value_errs++;
		end
		assert (count === '0)
		else
		begin
			$display("mismatch count: expected %h, got %h", cnt_t'(0), count);
			value_errs++;
		end
	endtask

	// single-sample bursts on corner operands
	task automatic corner_test;
		op_t x;
		x = rand_op();
		send_sample(8'd0, 8'd0, 1'b1);
		idle_cycles(3);
		send_sample(8'd255, 8'd255, 1'b1);
		idle_cycles(3);
		send_sample(8'd1, x, 1'b1);
		idle_cycles(3);
		send_sample(x, 8'd1, 1'b1);
		idle_cycles(3);
	endtask

	// no gaps anywhere and a new burst right after each last
	task automatic back_to_back_test;
		int len;
		for (int k = 0; k < B2B_BURSTS; k++)
		begin
			len = 2 + ($unsigned($random(seed)) % 19);
			for (int i = 0; i < len; i++)
				send_sample(rand_op(), rand_op(), i == len - 1);
		end
		idle_cycles(3);
	endtask

	task automatic gapped_test;
		int len;
		for (int k = 0; k < GAP_BURSTS; k++)
		begin
			len = 2 + ($unsigned($random(seed)) % 19);
			for (int i = 0; i < len; i++)
			begin
				send_sample(rand_op(), rand_op(), i == len - 1);
				// up to three idle cycles after each sample
				idle_cycles($unsigned($random(seed)) % 4);
			end
		end
		idle_cycles(3);
	endtask

	// accumulator and count both wrap
	task automatic wrap_test;
		for (int i = 0; i < WRAP_LEN; i++)
			send_sample(8'd255, 8'd255, i == WRAP_LEN - 1);
		idle_cycles(3);
	endtask

	// ----------------------------------------
	// main sequence and watchdog
	// ----------------------------------------

	initial
	begin
		rst = 1'b1;
		in_valid = 1'b0;
		in_last = 1'b0;
		a = '0;
		b = '0;
		check_reset();
		corner_test();
		back_to_back_test();
		gapped_test();
		wrap_test();
		idle_cycles(4);
		$display("errors: %0d value mismatches, %0d protocol errors", value_errs, proto_errs);
		if (value_errs + proto_errs == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_NS);
		$display("timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("errors: %0d value mismatches, %0d protocol errors", value_errs, proto_errs);
		$display("Result: FAILED");
		$finish;
	end

endmodule
